/* verilog.f */
sccb_pkg.sv
sccb_init_rom.sv
sccb_bit_engine.sv
sccb_init_seq.sv
sccb_regs.sv
sccb_init_top.sv
sccb_properties.sv
tb_sccb_init.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the sccb start-up testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sccb_init -f verilog.f -o sim_sccb

status=0
output=$(./obj_dir/sim_sccb 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, exit status $status"
	exit 1
fi

/* tb_sccb_init.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sccb_init
	import sccb_pkg::*;
();

	localparam int          RUN_TIMEOUT = 20000;	// cycles for one full table run
	localparam int          APB_TIMEOUT = 16;
	localparam int          POLL_LIMIT  = 100;
	localparam logic [31:0] ST_DONE     = 32'h1 << STAT_DONE_BIT;
	localparam logic [31:0] ST_ERR      = 32'h1 << STAT_ERR_BIT;
	localparam logic [31:0] ST_BUSY     = 32'h1 << STAT_BUSY_BIT;

	logic        CLK;
	logic        RST_N;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        scl;
	logic        sda_oe;
	logic        irq;
	logic        ack_pull;	// sensor side pull-down
	wire logic   sda;
	logic [31:0] rng_state;
	logic [31:0] rdata;
	logic [6:0]  rand_dev;

	// sensor model state
	logic        in_frame;
	int          bit_pos;	// 0..7 data, 8 ack
	int          byte_cnt;
	logic [7:0]  cur_byte;
	logic [7:0]  frame [3];
	logic [23:0] writes [$];	// {addr byte, reg, val}
	int          nack_entry;	// -1 acks everything
	int          nack_byte;

	assign sda = !sda_oe && !ack_pull;	// open drain with idle pull-up

	sccb_init_top #(
		.CLK_DIV (4)
	)
	dut
	(
		.CLK     (CLK),
		.RST_N   (RST_N),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.scl     (scl),
		.sda_oe  (sda_oe),
		.sda_in  (sda),
		.irq     (irq)
	);

	always #20 CLK = ~CLK;	// 40 ns

	// --------------------
	// sensor model
	// --------------------
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			in_frame = 1'b1;	// start condition
			bit_pos  = 0;
			byte_cnt = 0;
		end
	end

	always @(posedge sda)
	begin
		if (scl === 1'b1 && in_frame === 1'b1)
		begin
			in_frame = 1'b0;	// stop
			if (byte_cnt == 3)
				writes.push_back({frame[0], frame[1], frame[2]});
		end
	end

	always @(posedge scl)
	begin
		if (in_frame === 1'b1)
		begin
			if (bit_pos == 8)
			begin
				bit_pos  = 0;	// ack clock done
				byte_cnt = byte_cnt + 1;
			end
			else if (byte_cnt < 3)
			begin
				cur_byte = {cur_byte[6:0], sda};
				bit_pos  = bit_pos + 1;
				if (bit_pos == 8)
					frame[byte_cnt] = cur_byte;
			end
		end
	end

	// drive ack while scl low
	always @(negedge scl)
	begin
		@(negedge CLK);
		if (in_frame === 1'b1)
			ack_pull = (bit_pos == 8) &&
				!(writes.size() == nack_entry && byte_cnt == nack_byte);
	end

	// --------------------
	// helpers
	// --------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// sensor register table as {reg, val}
	function automatic logic [15:0] table_entry(input int idx);
		case (idx)
			0:       return 16'h1280;
			1:       return 16'h1101;
			2:       return 16'h3A04;
			3:       return 16'h40D0;
			4:       return 16'h8C00;
			5:       return 16'h1713;
			6:       return 16'h1801;
			default: return 16'h32B6;
		endcase
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timed out at %0t ns waiting for %s", $time, what);
		$display("Checks failed");
		$fatal(1, "timeout");
	endtask

	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] data);
		int cycles;
		cycles = 0;
		@(negedge CLK);	// setup
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge CLK);	// access
		apb_req.penable = 1'b1;
		@(negedge CLK);
		while (apb_rsp.pready !== 1'b1)
		begin
			cycles++;
			if (cycles > APB_TIMEOUT)
				fail_timeout("apb pready");
			@(negedge CLK);
		end
		data            = apb_rsp.prdata;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		apb_access(1'b1, addr, wdata, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb_access(1'b0, addr, 32'h0, data);
	endtask

	task automatic wait_irq(input string what);
		int cycles;
		cycles = 0;
		while (irq !== 1'b1)
		begin
			@(negedge CLK);
			cycles++;
			if (cycles > RUN_TIMEOUT)
				fail_timeout(what);
		end
	endtask

	task automatic wait_busy();
		logic [31:0] st;
		int polls;
		polls = 0;
		apb_read(REG_STATUS, st);
		while (st[STAT_BUSY_BIT] !== 1'b1)
		begin
			polls++;
			if (polls > POLL_LIMIT)
				fail_timeout("busy status bit");
			apb_read(REG_STATUS, st);
		end
	endtask

	task automatic check_writes(input logic [6:0] dev, input int count);
		check_eq(writes.size(), count, "number of sensor writes");
		for (int i = 0; i < count; i++)
			check_eq(writes[i], {dev, 1'b0, table_entry(i)}, $sformatf("sensor write %0d", i));
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic test_reset();
		apb_read(REG_STATUS, rdata);
		check_eq(rdata, 32'h0, "status after reset");
		apb_read(REG_DEV, rdata);
		check_eq(rdata, {25'h0, DEV_RESET}, "device address after reset");
		check_eq(irq, 1'b0, "irq after reset");
		check_eq({scl, sda_oe}, 2'b10, "bus idle after reset");
	endtask

	task automatic test_default_run();
		writes.delete();
		apb_write(REG_CTRL, 32'h1);
		wait_irq("done of default run");
		check_writes(DEV_RESET, INIT_LEN);
		apb_read(REG_STATUS, rdata);
		check_eq(rdata, ST_DONE, "status after default run");
		check_eq(irq, 1'b1, "irq after default run");
	endtask

	task automatic test_random_addr();
		rng_state = xorshift32(rng_state);
		rand_dev  = rng_state[6:0];
		apb_write(REG_DEV, {25'h0, rand_dev});
		apb_read(REG_DEV, rdata);
		check_eq(rdata, {25'h0, rand_dev}, "device address readback");
		writes.delete();
		apb_write(REG_CTRL, 32'h1);
		apb_read(REG_STATUS, rdata);
		check_eq(rdata, ST_BUSY, "status right after start");	// done cleared
		wait_irq("done of random address run");
		check_writes(rand_dev, INIT_LEN);
		apb_read(REG_STATUS, rdata);
		check_eq(rdata, ST_DONE, "status after random address run");
	endtask

	task automatic test_nack();
		nack_entry = 3;
		nack_byte  = 2;	// value byte
		writes.delete();
		apb_write(REG_CTRL, 32'h1);
		wait_irq("error of nack run");
		apb_read(REG_STATUS, rdata);
		check_eq(rdata, ST_ERR, "status after nack");
		check_writes(rand_dev, 4);
		check_eq(irq, 1'b1, "irq after nack");
		nack_entry = -1;
	endtask

	task automatic test_start_while_busy();
		writes.delete();
		apb_write(REG_CTRL, 32'h1);
		wait_busy();
		apb_write(REG_CTRL, 32'h1);	// must be dropped
		wait_irq("done of busy start run");
		check_writes(rand_dev, INIT_LEN);
		apb_read(REG_STATUS, rdata);
		check_eq(rdata, ST_DONE, "status after busy start run");
	endtask

	initial
	begin
		CLK        = 1'b0;
		RST_N      = 1'b0;
		apb_req    = '0;
		ack_pull   = 1'b0;
		in_frame   = 1'b0;
		bit_pos    = 0;
		byte_cnt   = 0;
		cur_byte   = 8'h0;
		nack_entry = -1;
		nack_byte  = 0;
		rng_state  = 32'ha413;
		rand_dev   = DEV_RESET;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;

		test_reset();
		test_default_run();
		test_random_addr();
		test_nack();
		test_start_while_busy();

		if (dut.props.fail_cnt != 0)
		begin
			$display("%0d assertion failures", dut.props.fail_cnt);
			$display("Checks failed");
			$fatal(1, "assertion failures");
		end
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sccb_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_properties
	import sccb_pkg::*;
(
	input wire logic     CLK,
	input wire logic     RST_N,
	input wire apb_req_t apb_req,
	input wire apb_rsp_t apb_rsp,
	input wire logic     scl,
	input wire logic     sda_oe,
	input wire logic     busy,
	input wire logic     irq
);

	int fail_cnt = 0;	// assertion failures so far

	// --------------------
	// bus pins
	// --------------------

	// zero wait states and no read data outside an access
	a_apb_rsp: assert property (@(posedge CLK) disable iff (!RST_N)
		apb_rsp.pready &&
		((apb_req.psel && apb_req.penable) || (apb_rsp.prdata == 32'h0)))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("apb response out of protocol");
	end

	// sda never moves on an scl edge
	a_sda_edge: assert property (@(posedge CLK) disable iff (!RST_N)
		$changed(sda_oe) |-> $stable(scl))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("sda_oe changed together with scl");
	end

	a_irq_idle: assert property (@(posedge CLK) disable iff (!RST_N) busy |-> !irq)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("irq high during a run");
	end

endmodule

bind sccb_init_top sccb_properties props
(
	.CLK     (CLK),
	.RST_N   (RST_N),
	.apb_req (apb_req),
	.apb_rsp (apb_rsp),
	.scl     (scl),
	.sda_oe  (sda_oe),
	.busy    (busy),
	.irq     (irq)
);

`default_nettype wire

/* sccb_init_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_init_top
	import sccb_pkg::*;
#(
	parameter int CLK_DIV = 4	// quarter-bit length in CLK cycles
)
(
	input  wire logic     CLK,
	input  wire logic     RST_N,
	input  wire apb_req_t apb_req,
	output apb_rsp_t      apb_rsp,
	output logic          scl,
	output logic          sda_oe,
	input  wire logic     sda_in,
	output logic          irq
);

	// --------------------
	// internal wiring
	// --------------------
	logic       start;
	logic       busy;
	logic       seq_done;
	logic       seq_err;
	logic [6:0] dev_addr;
	logic [2:0] entry_idx;
	logic [7:0] entry_reg;
	logic [7:0] entry_val;
	sccb_xfer_t xfer;
	logic       go;
	logic       xfer_done;
	logic       nack;

	sccb_regs u_regs
	(
		.CLK      (CLK),
		.RST_N    (RST_N),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.busy     (busy),
		.seq_done (seq_done),
		.seq_err  (seq_err),
		.start    (start),
		.dev_addr (dev_addr),
		.irq      (irq)
	);

	sccb_init_seq u_seq
	(
		.CLK       (CLK),
		.RST_N     (RST_N),
		.start     (start),
		.dev_addr  (dev_addr),
		.entry_idx (entry_idx),
		.entry_reg (entry_reg),
		.entry_val (entry_val),
		.xfer      (xfer),
		.go        (go),
		.xfer_done (xfer_done),
		.nack      (nack),
		.busy      (busy),
		.seq_done  (seq_done),
		.seq_err   (seq_err)
	);

	sccb_init_rom u_rom
	(
		.entry_idx (entry_idx),
		.entry_reg (entry_reg),
		.entry_val (entry_val)
	);

	sccb_bit_engine #(
		.CLK_DIV (CLK_DIV)
	)
	u_engine
	(
		.CLK       (CLK),
		.RST_N     (RST_N),
		.xfer      (xfer),
		.go        (go),
		.scl       (scl),
		.sda_oe    (sda_oe),
		.sda_in    (sda_in),
		.xfer_done (xfer_done),
		.nack      (nack)
	);

endmodule

`default_nettype wire

/* sccb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_regs
	import sccb_pkg::*;
(
	input  wire logic     CLK,
	input  wire logic     RST_N,
	input  wire apb_req_t apb_req,
	output apb_rsp_t      apb_rsp,
	input  wire logic     busy,
	input  wire logic     seq_done,
	input  wire logic     seq_err,
	output logic          start,
	output logic [6:0]    dev_addr,
	output logic          irq
);

	logic        access;	// apb access phase
	logic        wr;
	logic        rd;
	logic        start_wr;
	logic        sts_done;	// sticky
	logic        sts_err;	// sticky
	logic [31:0] status;
	logic [31:0] rdata;

	assign access   = apb_req.psel && apb_req.penable;
	assign wr       = access && apb_req.pwrite;
	assign rd       = access && !apb_req.pwrite;
	assign start_wr = wr && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0] && !busy;

	// --------------------
	// write side
	// --------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			start    <= 1'b0;
			dev_addr <= DEV_RESET;
			sts_done <= 1'b0;
			sts_err  <= 1'b0;
		end
		else
		begin
			start <= start_wr;	// one cycle, ignored while busy
			if (wr && (apb_req.paddr == REG_DEV))
				dev_addr <= apb_req.pwdata[6:0];
			if (start_wr)
			begin
				sts_done <= 1'b0;	// new run clears old status
				sts_err  <= 1'b0;
			end
			else
			begin
				if (seq_done)
					sts_done <= 1'b1;
				if (seq_err)
					sts_err <= 1'b1;
			end
		end
	end

	// --------------------
	// read side
	// --------------------
	always_comb
	begin
		status                = 32'h0;
		status[STAT_DONE_BIT] = sts_done;
		status[STAT_ERR_BIT]  = sts_err;
		status[STAT_BUSY_BIT] = busy;
	end

	always_comb
	begin
		rdata = 32'h0;	// ctrl reads back zero
		if (rd)
		begin
			case (apb_req.paddr)
				REG_DEV:    rdata = {25'h0, dev_addr};
				REG_STATUS: rdata = status;
				default:    rdata = 32'h0;
			endcase
		end
	end

	assign apb_rsp.prdata = rdata;
	assign apb_rsp.pready = 1'b1;	// zero wait states
	assign irq            = sts_done | sts_err;

endmodule

`default_nettype wire

/* sccb_init_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_init_seq
	import sccb_pkg::*;
(
	input  wire logic       CLK,
	input  wire logic       RST_N,
	input  wire logic       start,
	input  wire logic [6:0] dev_addr,
	output logic [2:0]      entry_idx,
	input  wire logic [7:0] entry_reg,
	input  wire logic [7:0] entry_val,
	output sccb_xfer_t      xfer,
	output logic            go,
	input  wire logic       xfer_done,
	input  wire logic       nack,
	output logic            busy,
	output logic            seq_done,
	output logic            seq_err
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_ISSUE,	// go rises here
		S_WAIT,		// engine busy
		S_GAP		// go low one cycle
	} state_t;

	localparam logic [2:0] LAST_IDX = 3'(INIT_LEN - 1);

	state_t state;

	// --------------------
	// table walk
	// --------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			state     <= S_IDLE;
			entry_idx <= 3'd0;
			seq_done  <= 1'b0;
			seq_err   <= 1'b0;
		end
		else
		begin
			seq_done <= 1'b0;
			seq_err  <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						entry_idx <= 3'd0;
						state     <= S_ISSUE;
					end
				end
				S_ISSUE:
					state <= S_WAIT;
				S_WAIT:
				begin
					if (xfer_done)
					begin
						if (nack)
						begin
							seq_err <= 1'b1;	// sensor silent, abort run
							state   <= S_IDLE;
						end
						else if (entry_idx == LAST_IDX)
						begin
							seq_done <= 1'b1;
							state    <= S_IDLE;
						end
						else
						begin
							entry_idx <= entry_idx + 3'd1;	// sync advance
							state     <= S_GAP;
						end
					end
				end
				default:
					state <= S_ISSUE;	// S_GAP
			endcase
		end
	end

	assign go   = (state == S_ISSUE) || (state == S_WAIT);
	assign busy = (state != S_IDLE);

	// stable while go is high, idx only moves in gap
	assign xfer.dev_addr = dev_addr;
	assign xfer.reg_addr = entry_reg;
	assign xfer.reg_val  = entry_val;

endmodule

`default_nettype wire

/* sccb_bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_bit_engine
	import sccb_pkg::*;
#(
	parameter int CLK_DIV = 4	// cycles per quarter bit, 2 or more
)
(
	input  wire logic       CLK,
	input  wire logic       RST_N,
	input  wire sccb_xfer_t xfer,
	input  wire logic       go,
	output logic            scl,
	output logic            sda_oe,	// 1 pulls sda low
	input  wire logic       sda_in,
	output logic            xfer_done,
	output logic            nack
);

	localparam int         TW        = $clog2(CLK_DIV);
	localparam logic [4:0] SLOT_STOP = 5'd28;	// start + 27 bits before it

	logic          active;
	logic          go_q;
	logic [TW-1:0] tick_cnt;
	logic          tick;		// last cycle of a quarter
	logic [1:0]    qtr;			// quarter within current slot
	logic [4:0]    slot;		// 0 start, 1..27 bits, 28 stop
	logic [3:0]    bit_cnt;		// 0..7 data, 8 ack
	logic [23:0]   shift;
	logic          launch;
	logic          data_slot;
	logic          ack_slot;
	logic          slot_end;
	logic [1:0]    sda_meta;	// input sync
	logic          scl_c;
	logic          oe_c;

	assign launch    = !active && go && !go_q;	// rising go only
	assign tick      = (tick_cnt == TW'(CLK_DIV - 1));
	assign data_slot = (slot != 5'd0) && (slot != SLOT_STOP);
	assign ack_slot  = data_slot && (bit_cnt == 4'd8);
	assign slot_end  = active && tick && (qtr == 2'd3);

	// --------------------
	// sequencing
	// --------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			active    <= 1'b0;
			go_q      <= 1'b0;
			tick_cnt  <= '0;
			qtr       <= 2'd0;
			slot      <= 5'd0;
			bit_cnt   <= 4'd0;
			nack      <= 1'b0;
			xfer_done <= 1'b0;
		end
		else
		begin
			go_q      <= go;
			xfer_done <= 1'b0;	// single-cycle pulse
			if (launch)
			begin
				active   <= 1'b1;
				tick_cnt <= '0;
				qtr      <= 2'd0;
				slot     <= 5'd0;
				bit_cnt  <= 4'd0;
				nack     <= 1'b0;	// fresh status per transfer
			end
			else if (active)
			begin
				tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
				// ack sampled at the middle of scl high
				if (ack_slot && (qtr == 2'd1) && tick && sda_meta[1])
					nack <= 1'b1;
				if (tick)
					qtr <= qtr + 2'd1;
				if (slot_end)
				begin
					if (slot == SLOT_STOP)
					begin
						active    <= 1'b0;
						xfer_done <= 1'b1;
					end
					else
						slot <= slot + 5'd1;
					if (data_slot)
						bit_cnt <= (bit_cnt == 4'd8) ? 4'd0 : bit_cnt + 4'd1;
				end
			end
		end
	end

	// payload, msb first
	always_ff @(posedge CLK)
	begin
		if (launch)
			shift <= {xfer.dev_addr, 1'b0, xfer.reg_addr, xfer.reg_val};
		else if (slot_end && data_slot && !ack_slot)
			shift <= {shift[22:0], 1'b0};
	end

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
			sda_meta <= 2'b11;	// idle line is high
		else
			sda_meta <= {sda_meta[0], sda_in};
	end

	// --------------------
	// pin waveform
	// --------------------
	always_comb
	begin
		scl_c = 1'b1;	// idle, bus released
		oe_c  = 1'b0;
		if (active)
		begin
			if (slot == 5'd0)
			begin
				scl_c = (qtr != 2'd3);
				oe_c  = (qtr != 2'd0);	// sda falls, scl high
			end
			else if (slot == SLOT_STOP)
			begin
				scl_c = (qtr != 2'd0);
				oe_c  = (qtr < 2'd2);	// sda rises, scl high
			end
			else
			begin
				scl_c = (qtr == 2'd1) || (qtr == 2'd2);
				oe_c  = !ack_slot && !shift[23];	// release for ack
			end
		end
	end

	// registered pins, no glitches
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			scl    <= 1'b1;
			sda_oe <= 1'b0;
		end
		else
		begin
			scl    <= scl_c;
			sda_oe <= oe_c;
		end
	end

endmodule

`default_nettype wire

/* sccb_init_rom.sv */
`timescale 1ns/1ps
`default_nettype none

// lookup of the sensor start-up table
module sccb_init_rom
(
	input  wire logic [2:0] entry_idx,
	output logic [7:0]      entry_reg,
	output logic [7:0]      entry_val
);

	always_comb
	begin
		case (entry_idx)
			3'd0:    {entry_reg, entry_val} = {8'h12, 8'h80};	// COM7 soft reset
			3'd1:    {entry_reg, entry_val} = {8'h11, 8'h01};	// clkrc prescale
			3'd2:    {entry_reg, entry_val} = {8'h3A, 8'h04};	// tslb output sequence
			3'd3:    {entry_reg, entry_val} = {8'h40, 8'hD0};	// COM15 rgb565 full range
			3'd4:    {entry_reg, entry_val} = {8'h8C, 8'h00};	// rgb444 off
			3'd5:    {entry_reg, entry_val} = {8'h17, 8'h13};	// hstart
			3'd6:    {entry_reg, entry_val} = {8'h18, 8'h01};	// hstop
			default: {entry_reg, entry_val} = {8'h32, 8'hB6};	// href edge offsets
		endcase
	end

endmodule

`default_nettype wire

/* sccb_pkg.sv */
`default_nettype none

package sccb_pkg;

	// --------------------
	// bus payloads
	// --------------------

	// one sccb write, 3-phase
	typedef struct packed {
		logic [6:0] dev_addr;	// 7-bit sensor id, write bit added on the wire
		logic [7:0] reg_addr;
		logic [7:0] reg_val;
	} sccb_xfer_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
	} apb_rsp_t;

	// --------------------
	// register map
	// --------------------
	localparam int INIT_LEN = 8;	// entries in the start-up table

	localparam logic [7:0] REG_CTRL   = 8'h00;	// bit 0 starts a run
	localparam logic [7:0] REG_DEV    = 8'h04;
	localparam logic [7:0] REG_STATUS = 8'h08;

	localparam int STAT_DONE_BIT = 0;
	localparam int STAT_ERR_BIT  = 1;
	localparam int STAT_BUSY_BIT = 2;

	localparam logic [6:0] DEV_RESET = 7'h21;	// 0x42 on the wire

endpackage

`default_nettype wire
